//--- Makefile
# Verilator simulation of the PS/2 controller testbench

VERILATOR ?= verilator
TOP       ?= tb_ps2_ctrl
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- ps2_batch_timer.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_batch_timer (
  input  wire logic wb_clk_i,
  input  wire logic wb_rst_i,
  input  wire logic mse_irq_i,   // Mouse interrupt output
  output logic      new_batch_o  // Interrupt starts a new packet
);

  logic [ps2_pkg::BATCH_PRE_W-1:0] pre_cnt;   // Prescaler, counts down
  logic [ps2_pkg::BATCH_CNT_W-1:0] idle_cnt;  // Ticks since last irq
  logic                            tick;
  logic                            irq_q;
  logic                            irq_rise;

  // ----------------------------------------------------------------------
  // 0.1 ms prescaler
  // ----------------------------------------------------------------------
  assign tick = (pre_cnt == '0);

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      pre_cnt <= ps2_pkg::BATCH_PRE_W'(ps2_pkg::BATCH_PRESCALE);
    end else if (tick) begin
      pre_cnt <= ps2_pkg::BATCH_PRE_W'(ps2_pkg::BATCH_PRESCALE);  // Reload
    end else begin
      pre_cnt <= pre_cnt - 1'b1;
    end
  end

  // Idle counter, held clear during the irq and saturating at all ones
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      idle_cnt <= '0;
    end else if (mse_irq_i) begin
      idle_cnt <= '0;
    end else if (tick && !(&idle_cnt)) begin
      idle_cnt <= idle_cnt + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Sample the idle time on the irq rising edge
  // ----------------------------------------------------------------------
  assign irq_rise = mse_irq_i & ~irq_q;

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      irq_q       <= 1'b0;
      new_batch_o <= 1'b0;
    end else begin
      irq_q <= mse_irq_i;
      if (irq_rise) new_batch_o <= idle_cnt[ps2_pkg::BATCH_CNT_W-1];  // 16+ ticks idle
    end
  end

  a_batch_on_rise: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !$stable(new_batch_o) |-> $past(irq_rise))
    else $error("new_batch changed without an irq edge");

endmodule

`default_nettype wire

//--- ps2_cmd_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_cmd_ctrl (
  input  wire logic       wb_clk_i,
  input  wire logic       wb_rst_i,
  input  wire logic [7:0] byte_i,           // Bus write byte
  input  wire logic       cmd_wr_i,
  input  wire logic       dat_wr_i,
  input  wire logic       dat_rd_i,
  input  wire logic [7:0] rx_byte_i,        // Mouse or keyboard byte
  input  wire logic       mse_done_i,       // Mouse finished sending
  output logic      [7:0] data_byte_o,      // Data port read value
  output logic            reply_pending_o,
  output logic            int_en_o,
  output logic            int2_en_o,
  output logic      [7:0] mse_dat_o,
  output logic            mse_send_o
);

  ps2_pkg::ps2_cmd_e cmd;
  logic        [7:0] cntl;       // Control byte
  logic              rd_cntl;    // Next data read returns cntl
  logic              wr_cntl;    // Next data write loads cntl
  logic              self_test;  // Next data read returns 0x55
  logic              mse_test;   // Next data read returns 0x00
  logic              mse_send;   // Next data write goes to the mouse

  assign cmd = ps2_pkg::ps2_cmd_e'(byte_i);

  // ----------------------------------------------------------------------
  // Command flags and control byte
  // ----------------------------------------------------------------------
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      cntl      <= ps2_pkg::CNTL_RESET;
      rd_cntl   <= 1'b0;
      wr_cntl   <= 1'b0;
      self_test <= 1'b0;
      mse_test  <= 1'b0;
      mse_send  <= 1'b0;
    end else begin
      if (cmd_wr_i) begin
        case (cmd)
          ps2_pkg::CMD_RD_CNTL:   rd_cntl <= 1'b1;
          ps2_pkg::CMD_WR_CNTL: begin
            wr_cntl  <= 1'b1;
            mse_send <= 1'b0;  // Control write cancels a mouse send
          end
          ps2_pkg::CMD_MSE_WRITE: mse_send  <= 1'b1;
          ps2_pkg::CMD_SELF_TEST: self_test <= 1'b1;
          ps2_pkg::CMD_MSE_TEST:  mse_test  <= 1'b1;
          default: ;  // Other opcodes ignored
        endcase
      end else if (dat_rd_i) begin
        rd_cntl   <= 1'b0;  // Reply consumed
        self_test <= 1'b0;
        mse_test  <= 1'b0;
      end else if (dat_wr_i && wr_cntl) begin
        cntl    <= byte_i;
        wr_cntl <= 1'b0;
      end
      if (mse_send && mse_done_i) begin
        mse_send <= 1'b0;  // Mouse took the byte
      end
    end
  end

  assign reply_pending_o = rd_cntl | self_test | mse_test;

  // Reply bytes take priority over received data
  assign data_byte_o = rd_cntl   ? cntl :
                       self_test ? ps2_pkg::SELF_TEST_OK :
                       mse_test  ? ps2_pkg::MSE_TEST_OK : rx_byte_i;

  assign int_en_o  = cntl[ps2_pkg::CNTL_INT_BIT];
  assign int2_en_o = cntl[ps2_pkg::CNTL_INT2_BIT];

  // One pulse per data write while the send flag is armed
  assign mse_send_o = mse_send & dat_wr_i;
  assign mse_dat_o  = byte_i;

  a_send_on_write: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    mse_send_o |-> dat_wr_i)
    else $error("mouse send outside a data write");

endmodule

`default_nettype wire

//--- ps2_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_ctrl (
  input  wire logic        wb_clk_i,
  input  wire logic        wb_rst_i,
  input  wire logic [15:0] wb_dat_i,
  output logic      [15:0] wb_dat_o,
  input  wire logic        wb_cyc_i,
  input  wire logic        wb_stb_i,
  input  wire logic  [2:1] wb_adr_i,
  input  wire logic  [1:0] wb_sel_i,
  input  wire logic        wb_we_i,
  output logic             wb_ack_o,
  output logic             wb_tgk_o,      // Keyboard IRQ
  output logic             wb_tgm_o,      // Mouse IRQ
  output logic       [7:0] mse_dat_o,     // Byte to the mouse
  output logic             mse_send_o,
  input  wire logic        mse_done_i,
  input  wire logic  [7:0] mse_rx_dat_i,  // Byte from the mouse
  input  wire logic        mse_rdy_i,
  input  wire logic        mse_toer_i,
  input  wire logic        mse_over_i,
  input  wire logic  [7:0] kbd_dat_i,
  input  wire logic        kbd_rdy_i,
  output logic             kbd_rd_o
);

  logic [7:0] wr_byte;
  logic       dat_wr;
  logic       dat_rd;
  logic       cmd_wr;
  logic [7:0] data_byte;
  logic       reply_pending;
  logic       int_en;
  logic       int2_en;
  logic [7:0] rx_byte;
  logic [7:0] status;
  logic       new_batch;

  ps2_wb_slave u_wb_slave (
    .wb_clk_i    (wb_clk_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_adr_i    (wb_adr_i),
    .wb_sel_i    (wb_sel_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_ack_o    (wb_ack_o),
    .byte_o      (wr_byte),
    .dat_wr_o    (dat_wr),
    .dat_rd_o    (dat_rd),
    .cmd_wr_o    (cmd_wr),
    .data_byte_i (data_byte),
    .status_i    (status),
    .new_batch_i (new_batch)
  );

  ps2_cmd_ctrl u_cmd_ctrl (
    .wb_clk_i        (wb_clk_i),
    .wb_rst_i        (wb_rst_i),
    .byte_i          (wr_byte),
    .cmd_wr_i        (cmd_wr),
    .dat_wr_i        (dat_wr),
    .dat_rd_i        (dat_rd),
    .rx_byte_i       (rx_byte),
    .mse_done_i      (mse_done_i),
    .data_byte_o     (data_byte),
    .reply_pending_o (reply_pending),
    .int_en_o        (int_en),
    .int2_en_o       (int2_en),
    .mse_dat_o       (mse_dat_o),
    .mse_send_o      (mse_send_o)
  );

  ps2_rx_select u_rx_select (
    .wb_clk_i        (wb_clk_i),
    .wb_rst_i        (wb_rst_i),
    .mse_rdy_i       (mse_rdy_i),
    .mse_rx_dat_i    (mse_rx_dat_i),
    .kbd_dat_i       (kbd_dat_i),
    .kbd_rdy_i       (kbd_rdy_i),
    .dat_rd_i        (dat_rd),
    .reply_pending_i (reply_pending),
    .int_en_i        (int_en),
    .int2_en_i       (int2_en),
    .mse_done_i      (mse_done_i),
    .mse_toer_i      (mse_toer_i),
    .mse_over_i      (mse_over_i),
    .rx_byte_o       (rx_byte),
    .kbd_rd_o        (kbd_rd_o),
    .status_o        (status),
    .wb_tgk_o        (wb_tgk_o),
    .wb_tgm_o        (wb_tgm_o)
  );

  // Watchdog runs off the gated mouse IRQ
  ps2_batch_timer u_batch_timer (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .mse_irq_i   (wb_tgm_o),
    .new_batch_o (new_batch)
  );

endmodule

`default_nettype wire

//--- ps2_pkg.sv
`default_nettype none

package ps2_pkg;

  // ----------------------------------------------------------------------
  // Register map, the 3-bit address is {wb_adr_i, wb_sel_i[1]}
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {
    PS2_DATA_REG  = 3'b000,  // Port 0x60, data in and out
    PS2_BATCH_REG = 3'b010,  // Port 0x62, read only batch flag
    PS2_CMD_REG   = 3'b100   // Port 0x64, status read and command write
  } ps2_reg_e;

  // ----------------------------------------------------------------------
  // Controller opcodes written to the command port
  // ----------------------------------------------------------------------
  typedef enum logic [7:0] {
    CMD_RD_CNTL   = 8'h20,  // Next data read returns the control byte
    CMD_WR_CNTL   = 8'h60,  // Next data write loads the control byte
    CMD_MSE_TEST  = 8'hA9,  // Mouse interface test
    CMD_SELF_TEST = 8'hAA,  // Controller self test
    CMD_MSE_WRITE = 8'hD4   // Next data write goes out to the mouse
  } ps2_cmd_e;

  // Control byte, bits 2 and 4..6 are kept but unused here
  localparam logic [7:0] CNTL_RESET    = 8'h47;
  localparam int         CNTL_INT_BIT  = 0;  // Keyboard IRQ enable
  localparam int         CNTL_INT2_BIT = 1;  // Mouse IRQ enable

  // Reply bytes for the test commands
  localparam logic [7:0] SELF_TEST_OK = 8'h55;
  localparam logic [7:0] MSE_TEST_OK  = 8'h00;

  // Status bits 3..1 as {SYS, A2, OBF}
  localparam logic [2:0] STAT_FIXED = 3'b101;
  localparam logic       STAT_INH   = 1'b1;  // Keyboard never inhibited

  // Batch port
  localparam logic [6:0] BATCH_TAG = 7'b1010000;  // Upper bits of port 0x62

  // ----------------------------------------------------------------------
  // Batch watchdog, one tick per BATCH_PRESCALE+1 clocks (0.1 ms at 12.5 MHz)
  // ----------------------------------------------------------------------
  localparam int BATCH_PRESCALE = 1250;
  localparam int BATCH_PRE_W    = 11;  // Holds 0..1250
  localparam int BATCH_CNT_W    = 5;   // Idle counter, top bit means 16+ ticks

endpackage

`default_nettype wire

//--- ps2_rx_select.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_rx_select (
  input  wire logic       wb_clk_i,
  input  wire logic       wb_rst_i,
  input  wire logic       mse_rdy_i,        // Mouse byte ready pulse
  input  wire logic [7:0] mse_rx_dat_i,
  input  wire logic [7:0] kbd_dat_i,
  input  wire logic       kbd_rdy_i,        // Keyboard FIFO not empty
  input  wire logic       dat_rd_i,
  input  wire logic       reply_pending_i,  // Command reply still waiting
  input  wire logic       int_en_i,
  input  wire logic       int2_en_i,
  input  wire logic       mse_done_i,
  input  wire logic       mse_toer_i,
  input  wire logic       mse_over_i,
  output logic      [7:0] rx_byte_o,
  output logic            kbd_rd_o,         // Pops the keyboard FIFO
  output logic      [7:0] status_o,
  output logic            wb_tgk_o,
  output logic            wb_tgm_o
);

  logic mse_int;  // Mouse receive interrupt latch
  logic host_rd;  // Data read that takes received data
  logic ibf;

  // A read with a reply pending returns the reply, not device data
  assign host_rd = dat_rd_i & ~reply_pending_i;

  // ----------------------------------------------------------------------
  // Mouse interrupt latch, a host read wins over a new byte
  // ----------------------------------------------------------------------
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      mse_int <= 1'b0;
    end else begin
      if (mse_rdy_i) mse_int <= 1'b1;
      if (host_rd)   mse_int <= 1'b0;
    end
  end

  // Mouse byte first, keyboard only when no mouse byte waits
  assign rx_byte_o = mse_int ? mse_rx_dat_i : kbd_dat_i;
  assign kbd_rd_o  = host_rd & ~mse_int;

  // Interrupt outputs gated by the control byte enables
  assign wb_tgm_o = mse_int   & int2_en_i;
  assign wb_tgk_o = kbd_rdy_i & int_en_i;

  // ----------------------------------------------------------------------
  // Status byte {PERR, TO, MOBF, INH, SYS, A2, OBF, IBF}
  // ----------------------------------------------------------------------
  assign ibf      = mse_int | kbd_rdy_i | reply_pending_i;
  assign status_o = {mse_over_i, mse_toer_i, mse_done_i, ps2_pkg::STAT_INH,
                     ps2_pkg::STAT_FIXED, ibf};

  // Keyboard pops only when neither a reply nor a mouse byte is due
  a_kbd_rd_excl: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    kbd_rd_o |-> !mse_int && !reply_pending_i)
    else $error("keyboard read while mouse byte or reply pending");

endmodule

`default_nettype wire

//--- ps2_wb_slave.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_wb_slave (
  input  wire logic        wb_clk_i,
  input  wire logic [15:0] wb_dat_i,
  output logic      [15:0] wb_dat_o,
  input  wire logic  [2:1] wb_adr_i,
  input  wire logic  [1:0] wb_sel_i,
  input  wire logic        wb_cyc_i,
  input  wire logic        wb_stb_i,
  input  wire logic        wb_we_i,
  output logic             wb_ack_o,
  output logic       [7:0] byte_o,       // Write byte from the selected lane
  output logic             dat_wr_o,     // Data port write strobe
  output logic             dat_rd_o,     // Data port read strobe
  output logic             cmd_wr_o,     // Command port write strobe
  input  wire logic  [7:0] data_byte_i,  // Data port read value
  input  wire logic  [7:0] status_i,     // Status byte
  input  wire logic        new_batch_i   // Batch watchdog flag
);

  ps2_pkg::ps2_reg_e reg_adr;
  logic              wr_acc;
  logic              rd_acc;
  logic              dat_sel;
  logic              cmd_sel;
  logic              batch_sel;
  logic        [7:0] rd_byte;

  // Byte address, the high select line stands in for A0
  assign reg_adr = ps2_pkg::ps2_reg_e'({wb_adr_i, wb_sel_i[1]});

  assign dat_sel   = (reg_adr == ps2_pkg::PS2_DATA_REG);
  assign cmd_sel   = (reg_adr == ps2_pkg::PS2_CMD_REG);
  assign batch_sel = (reg_adr == ps2_pkg::PS2_BATCH_REG);

  // ----------------------------------------------------------------------
  // Immediate acknowledge, no wait states
  // ----------------------------------------------------------------------
  assign wb_ack_o = wb_stb_i & wb_cyc_i;
  assign wr_acc   = wb_ack_o &  wb_we_i;
  assign rd_acc   = wb_ack_o & ~wb_we_i;

  assign dat_wr_o = dat_sel & wr_acc;
  assign dat_rd_o = dat_sel & rd_acc;
  assign cmd_wr_o = cmd_sel & wr_acc;

  // Low lane when sel[0] is set, else high lane
  assign byte_o = wb_sel_i[0] ? wb_dat_i[7:0] : wb_dat_i[15:8];

  // Read data select, status is the fallback
  assign rd_byte = batch_sel ? {ps2_pkg::BATCH_TAG, new_batch_i} :
                   dat_sel   ? data_byte_i : status_i;

  // Same lane as the access, the other lane reads zero
  assign wb_dat_o = wb_sel_i[0] ? {8'h00, rd_byte} : {rd_byte, 8'h00};

  // Every strobe comes from an acknowledged cycle, never two at once
  a_ack_stb: assert property (@(posedge wb_clk_i)
    wb_ack_o |-> wb_stb_i && !(dat_wr_o && dat_rd_o))
    else $error("ack without strobe or overlapping strobes");

endmodule

`default_nettype wire

//--- src.f
ps2_pkg.sv
ps2_wb_slave.sv
ps2_cmd_ctrl.sv
ps2_rx_select.sv
ps2_batch_timer.sv
ps2_ctrl.sv
tb_ps2_ctrl.sv

//--- tb_ps2_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ps2_ctrl;

  typedef enum {OP_WR, OP_RD, OP_MSE, OP_KBD, OP_LVL, OP_IDLE,
                OP_TGM, OP_TGK, OP_SEND, OP_KRD} op_e;

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic  [2:1] wb_adr_i;
  logic  [1:0] wb_sel_i;
  logic        wb_we_i;
  logic        wb_ack_o;
  logic        wb_tgk_o;
  logic        wb_tgm_o;
  logic  [7:0] mse_dat_o;
  logic        mse_send_o;
  logic        mse_done_i;
  logic  [7:0] mse_rx_dat_i;
  logic        mse_rdy_i;
  logic        mse_toer_i;
  logic        mse_over_i;
  logic  [7:0] kbd_dat_i;
  logic        kbd_rdy_i;
  logic        kbd_rd_o;

  // Stimulus table, one entry per row in every queue
  op_e         row_op[$];
  logic  [2:0] row_reg[$];
  logic        row_low[$];   // 1 selects the low lane
  logic  [7:0] row_dat[$];
  logic [15:0] row_exp[$];   // Cycle count on idle rows
  string       row_name[$];

  logic        done_lvl;     // Level forced onto mse_done_i
  logic        done_pulse;   // Answer of the mouse model
  logic  [7:0] kbd_q[$];     // Keyboard FIFO model
  int          send_cnt = 0;
  logic  [7:0] send_byte = 8'h00;
  int          done_wait = 0;
  int          kbd_rd_cnt = 0;
  int          checks = 0;
  int          errors = 0;
  int          limit_cycles = 0;

  assign mse_done_i = done_lvl | done_pulse;

  ps2_ctrl UUT (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever #2 wb_clk_i = ~wb_clk_i;  // 4 ns period
  end

  // --------------------------------------------------------------------
  // Device models
  // --------------------------------------------------------------------
  always @(posedge wb_clk_i) begin
    if (mse_send_o) begin
      send_cnt  = send_cnt + 1;
      send_byte = mse_dat_o;
      done_wait = 2;  // Done comes back two cycles later
    end else if (done_wait != 0) begin
      done_wait = done_wait - 1;
    end
    if (kbd_rd_o) begin
      kbd_rd_cnt = kbd_rd_cnt + 1;
      if (kbd_q.size() != 0) void'(kbd_q.pop_front());
    end
  end

  initial begin
    done_pulse = 1'b0;
    kbd_rdy_i  = 1'b0;
    kbd_dat_i  = 8'h00;
    forever begin
      @(negedge wb_clk_i);
      done_pulse = (done_wait == 1);
      kbd_rdy_i  = (kbd_q.size() != 0);  // Byte held until popped
      kbd_dat_i  = (kbd_q.size() != 0) ? kbd_q[0] : 8'h00;
    end
  end

  // Status byte {PERR, TO, MOBF, INH, SYS, A2, OBF, IBF}
  function automatic logic [7:0] stat_byte(input logic over, input logic toer,
                                           input logic done, input logic ibf);
    return {over, toer, done, 1'b1, 1'b1, 1'b0, 1'b1, ibf};
  endfunction

  function automatic logic [15:0] lane_word(input logic low, input logic [7:0] b);
    return low ? {8'h00, b} : {b, 8'h00};
  endfunction

  task automatic add_row(input op_e op, input logic [2:0] rg, input logic low,
                         input logic [7:0] dat, input logic [15:0] exp, input string name);
    row_op.push_back(op);
    row_reg.push_back(rg);
    row_low.push_back(low);
    row_dat.push_back(dat);
    row_exp.push_back(exp);
    row_name.push_back(name);
  endtask

  task automatic check(input string name, input logic [15:0] exp, input logic [15:0] got);
    checks = checks + 1;
    assert (got === exp) else begin
      errors = errors + 1;
      $display("FAIL %s: expected %h, actual %h", name, exp, got);
    end
  endtask

  // One Wishbone cycle, entered and left just after a falling edge
  task automatic bus_cycle(input string name, input logic we, input logic [2:0] rg,
                           input logic low, input logic [7:0] dat,
                           output logic [15:0] rdata);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = rg[2:1];
    wb_sel_i = {rg[0], low};  // High select doubles as A0
    wb_dat_i = lane_word(low, dat);
    #1;
    rdata = wb_dat_o;
    check({name, " ack"}, 16'h0001, {15'h0000, wb_ack_o});
    @(negedge wb_clk_i);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  // --------------------------------------------------------------------
  // Watchdog
  // --------------------------------------------------------------------
  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge wb_clk_i);
    $display("Watchdog expired after %0d cycles, the test did not finish", limit_cycles);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    logic [15:0] got;
    logic  [7:0] r_cntl;
    logic  [7:0] r_off;
    logic  [7:0] r_s1;
    logic  [7:0] r_s2;
    logic  [7:0] m [5];
    logic  [7:0] k [2];
    wb_rst_i = 1'b1;
    wb_dat_i = 16'h0000;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_adr_i = 2'b00;
    wb_sel_i = 2'b00;
    wb_we_i  = 1'b0;
    mse_rx_dat_i = 8'h00;
    mse_rdy_i    = 1'b0;
    mse_toer_i   = 1'b0;
    mse_over_i   = 1'b0;
    done_lvl     = 1'b0;
    void'($urandom(32'h4b8e));
    r_cntl = (8'($urandom) & 8'hFC) | 8'h03;  // Both interrupts stay enabled
    r_off  = (8'($urandom) & 8'hFC) | 8'h01;  // Mouse interrupt masked
    r_s1   = 8'($urandom);
    r_s2   = 8'($urandom);
    foreach (m[i]) m[i] = 8'($urandom);
    foreach (k[i]) k[i] = 8'($urandom);

    // ------------------------------------------------------------------
    // Table: control byte, test replies, mouse write, receive, status, batch
    // ------------------------------------------------------------------
    add_row(OP_WR,  3'b100, 1, 8'h20, 16'h0, "cmd read cntl");
    add_row(OP_RD,  3'b000, 1, 8'h00, 16'h47, "cntl after reset");
    add_row(OP_RD,  3'b100, 1, 8'h00, 16'(stat_byte(0, 0, 0, 0)), "status idle");
    add_row(OP_WR,  3'b100, 1, 8'h60, 16'h0, "cmd write cntl");
    add_row(OP_WR,  3'b000, 1, r_cntl, 16'h0, "cntl random byte");
    add_row(OP_WR,  3'b100, 0, 8'h20, 16'h0, "cmd read cntl high");
    add_row(OP_RD,  3'b000, 0, 8'h00, 16'(r_cntl), "cntl high lane");
    add_row(OP_WR,  3'b100, 1, 8'hAA, 16'h0, "cmd self test");
    add_row(OP_RD,  3'b100, 1, 8'h00, 16'(stat_byte(0, 0, 0, 1)), "ibf reply pending");
    add_row(OP_RD,  3'b000, 1, 8'h00, 16'h55, "self test reply");
    add_row(OP_RD,  3'b100, 1, 8'h00, 16'(stat_byte(0, 0, 0, 0)), "ibf after reply");
    add_row(OP_WR,  3'b100, 1, 8'hA9, 16'h0, "cmd mouse test");
    add_row(OP_RD,  3'b100, 1, 8'h00, 16'(stat_byte(0, 0, 0, 1)), "ibf mouse test");
    add_row(OP_RD,  3'b000, 0, 8'h00, 16'h00, "mouse test reply");
    add_row(OP_RD,  3'b100, 1, 8'h00, 16'(stat_byte(0, 0, 0, 0)), "ibf after mouse test");
    add_row(OP_WR,  3'b100, 1, 8'hD4, 16'h0, "cmd mouse write");
    add_row(OP_WR,  3'b000, 1, r_s1, 16'h0, "mouse write byte");
    add_row(OP_IDLE, 3'b000, 1, 8'h00, 16'd4, "wait mouse done");
    add_row(OP_SEND, 3'b000, 1, 8'h00, {8'd1, r_s1}, "one mouse send");
    add_row(OP_WR,  3'b000, 1, r_s2, 16'h0, "data write no d4");
    add_row(OP_IDLE, 3'b000, 1, 8'h00, 16'd4, "wait after write");
    add_row(OP_SEND, 3'b000, 1, 8'h00, {8'd1, r_s1}, "no send without d4");
    add_row(OP_MSE, 3'b000, 1, m[0], 16'h0, "mouse byte");
    add_row(OP_KBD, 3'b000, 1, k[0], 16'h0, "keyboard byte");
    add_row(OP_TGK, 3'b000, 1, 8'h00, 16'h1, "keyboard irq raised");
    add_row(OP_TGM, 3'b000, 1, 8'h00, 16'h1, "mouse irq raised");
    add_row(OP_RD,  3'b000, 1, 8'h00, 16'(m[0]), "mouse byte first");
    add_row(OP_KRD, 3'b000, 1, 8'h00, 16'd0, "no keyboard pop yet");
    add_row(OP_RD,  3'b000, 1, 8'h00, 16'(k[0]), "keyboard byte second");
    add_row(OP_KRD, 3'b000, 1, 8'h00, 16'd1, "keyboard popped");
    add_row(OP_TGK, 3'b000, 1, 8'h00, 16'h0, "keyboard irq cleared");
    add_row(OP_WR,  3'b100, 1, 8'h60, 16'h0, "cmd write cntl");
    add_row(OP_WR,  3'b000, 1, r_off, 16'h0, "cntl mouse irq off");
    add_row(OP_MSE, 3'b000, 1, m[1], 16'h0, "masked mouse byte");
    add_row(OP_TGM, 3'b000, 1, 8'h00, 16'h0, "mouse irq masked");
    add_row(OP_RD,  3'b000, 1, 8'h00, 16'(m[1]), "masked byte read");
    add_row(OP_WR,  3'b100, 1, 8'h60, 16'h0, "cmd write cntl");
    add_row(OP_WR,  3'b000, 1, 8'h47, 16'h0, "cntl restore");
    add_row(OP_LVL, 3'b000, 1, 8'h05, 16'h0, "overrun and done");
    add_row(OP_RD,  3'b100, 1, 8'h00, 16'(stat_byte(1, 0, 1, 0)), "status overrun");
    add_row(OP_LVL, 3'b000, 1, 8'h02, 16'h0, "timeout");
    add_row(OP_RD,  3'b100, 1, 8'h00, 16'(stat_byte(0, 1, 0, 0)), "status timeout");
    add_row(OP_LVL, 3'b000, 1, 8'h00, 16'h0, "levels low");
    add_row(OP_KBD, 3'b000, 1, k[1], 16'h0, "keyboard byte");
    add_row(OP_RD,  3'b100, 0, 8'h00, 16'(stat_byte(0, 0, 0, 1)), "ibf keyboard");
    add_row(OP_RD,  3'b000, 1, 8'h00, 16'(k[1]), "keyboard drain");
    add_row(OP_MSE, 3'b000, 1, m[2], 16'h0, "mouse byte");
    add_row(OP_RD,  3'b100, 1, 8'h00, 16'(stat_byte(0, 0, 0, 1)), "ibf mouse");
    add_row(OP_RD,  3'b000, 1, 8'h00, 16'(m[2]), "mouse drain");
    add_row(OP_IDLE, 3'b000, 1, 8'h00, 16'(20 * 1251), "batch idle");
    add_row(OP_MSE, 3'b000, 1, m[3], 16'h0, "mouse after idle");
    add_row(OP_IDLE, 3'b000, 1, 8'h00, 16'd2, "batch settle");
    add_row(OP_RD,  3'b010, 1, 8'h00, 16'hA1, "new batch");
    add_row(OP_RD,  3'b000, 1, 8'h00, 16'(m[3]), "batch byte read");
    add_row(OP_MSE, 3'b000, 1, m[4], 16'h0, "mouse soon after");
    add_row(OP_IDLE, 3'b000, 1, 8'h00, 16'd2, "batch settle");
    add_row(OP_RD,  3'b010, 1, 8'h00, 16'hA0, "same batch");
    add_row(OP_RD,  3'b000, 1, 8'h00, 16'(m[4]), "last byte read");
    limit_cycles = 4 * row_op.size() + 40000;

    repeat (4) @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    wb_rst_i = 1'b0;

    for (int i = 0; i < row_op.size(); i++) begin
      case (row_op[i])
        OP_WR: bus_cycle(row_name[i], 1'b1, row_reg[i], row_low[i], row_dat[i], got);
        OP_RD: begin
          bus_cycle(row_name[i], 1'b0, row_reg[i], row_low[i], 8'h00, got);
          check(row_name[i], lane_word(row_low[i], row_exp[i][7:0]), got);
        end
        OP_MSE: begin
          mse_rx_dat_i = row_dat[i];  // Byte stays on the port
          mse_rdy_i    = 1'b1;
          @(negedge wb_clk_i);
          mse_rdy_i    = 1'b0;
        end
        OP_KBD: begin
          kbd_q.push_back(row_dat[i]);
          repeat (2) @(negedge wb_clk_i);  // Model raises ready by then
        end
        OP_LVL: begin
          mse_over_i = row_dat[i][0];
          mse_toer_i = row_dat[i][1];
          done_lvl   = row_dat[i][2];
          @(negedge wb_clk_i);
        end
        OP_IDLE: repeat (row_exp[i]) @(negedge wb_clk_i);
        OP_TGM: begin
          #1;  // Sample after the models settle
          check(row_name[i], row_exp[i], {15'h0000, wb_tgm_o});
          @(negedge wb_clk_i);
        end
        OP_TGK: begin
          #1;
          check(row_name[i], row_exp[i], {15'h0000, wb_tgk_o});
          @(negedge wb_clk_i);
        end
        OP_SEND: check(row_name[i], row_exp[i], {8'(send_cnt), send_byte});
        OP_KRD:  check(row_name[i], row_exp[i], 16'(kbd_rd_cnt));
        default: begin
          errors = errors + 1;
          $display("Unknown table operation in row %0d", i);
        end
      endcase
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
